// ==== Bender.yml ====
package:
  name: lsu

sources:
  - include_dirs:
      - common
    files:
      - common/lsu_pkg.sv
      - common/dram_if.sv
      - lsu/lsu_store_align.sv
      - lsu/lsu_load_align.sv
      - verilog/dram_lane.sv
      - verilog/lsu_top.sv
      - target: test
        files:
          - testbench/tb_lsu_top.sv

// ==== common/dram_if.sv ====
`default_nettype none

`include "lsu_params.svh"

interface dram_if import lsu_pkg::*;
();

   logic [`LSU_DRAM_AW-4:0] addr; // Word address.
   lane_mask_t              we;   // Per-lane write enables.
   logic                    re;
   logic [63:0]             din;
   wire  [63:0]             dout; // Each lane drives its own byte.

   modport master
   (
      output addr,
      output we,
      output re,
      output din
   );

   modport lanes
   (
      input  addr,
      input  we,
      input  re,
      input  din,
      output dout
   );

   modport monitor
   (
      input re,
      input dout
   );

endinterface

`default_nettype wire

// ==== common/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Byte address width of the data RAM.
`define LSU_DRAM_AW 16

// Byte lanes per 64-bit word.
`define LSU_LANES 8

`endif

// ==== common/lsu_pkg.sv ====
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

   // Access size as a byte count.
   typedef logic [3:0] lsu_size_t;

   localparam lsu_size_t SIZE_B = 4'd1; // Byte.
   localparam lsu_size_t SIZE_H = 4'd2; // Half word.
   localparam lsu_size_t SIZE_W = 4'd4; // Word.
   localparam lsu_size_t SIZE_D = 4'd8; // Double word.

   // One write enable per byte lane.
   typedef logic [`LSU_LANES-1:0] lane_mask_t;

   // Byte offset within a 64-bit word.
   typedef logic [2:0] lane_offset_t;

   // True for the four byte counts the LSU decodes.
   function automatic logic size_is_legal(lsu_size_t size);
      logic legal;
      legal = (size == SIZE_B) ||
              (size == SIZE_H) ||
              (size == SIZE_W) ||
              (size == SIZE_D);
      return legal;
   endfunction

endpackage

`default_nettype wire

// ==== list.f ====
+incdir+common
common/lsu_pkg.sv
common/dram_if.sv
lsu/lsu_store_align.sv
lsu/lsu_load_align.sv
verilog/dram_lane.sv
verilog/lsu_top.sv
testbench/tb_lsu_top.sv

// ==== lsu/lsu_load_align.sv ====
`default_nettype none

`include "lsu_params.svh"

module lsu_load_align import lsu_pkg::*;
(
   input  wire               i_clk,
   input  wire               i_arst_n,
   input  wire               i_op_load,
   input  wire               i_sigext,
   input  wire lsu_size_t    i_size,
   input  wire lane_offset_t i_offset,
   dram_if.monitor           i_dram,
   output logic [63:0]       o_load_data,
   output logic              o_load_valid
);

   lsu_size_t    size_q;
   lane_offset_t offset_q;
   logic         sigext_q;
   logic         valid_q;
   logic [7:0]   res_b;
   logic [15:0]  res_h;
   logic [31:0]  res_w;

   // Attributes held until the RAM word comes back.
   always_ff @(posedge i_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         size_q   <= '0;
         offset_q <= '0;
         sigext_q <= 1'b0;
         valid_q  <= 1'b0;
      end
      else
      begin
         valid_q <= i_dram.re; // Lanes answer one cycle later.
         if (i_op_load)
         begin
            size_q   <= i_size;
            offset_q <= i_offset;
            sigext_q <= i_sigext;
         end
      end
   end

   // Fields at the naturally aligned position.
   assign res_b = i_dram.dout[{offset_q, 3'b000} +: 8];
   assign res_h = i_dram.dout[{offset_q[2:1], 4'b0000} +: 16];
   assign res_w = i_dram.dout[{offset_q[2], 5'b00000} +: 32];

   always_comb
   begin
      case (size_q)
         SIZE_B:
            o_load_data = {{56{sigext_q & res_b[7]}}, res_b};
         SIZE_H:
            o_load_data = {{48{sigext_q & res_h[15]}}, res_h};
         SIZE_W:
            o_load_data = {{32{sigext_q & res_w[31]}}, res_w};
         default:
            o_load_data = i_dram.dout;
      endcase
   end

   assign o_load_valid = valid_q;

   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_load_valid |-> size_is_legal(size_q))
      else $error("load result with illegal size %0d", size_q);

endmodule

`default_nettype wire

// ==== lsu/lsu_store_align.sv ====
`default_nettype none

`include "lsu_params.svh"

module lsu_store_align import lsu_pkg::*;
(
   input  wire                    i_op_load,
   input  wire                    i_op_store,
   input  wire lsu_size_t         i_size,
   input  wire [`LSU_DRAM_AW-1:0] i_addr,
   input  wire [63:0]             i_store_data,
   dram_if.master                 o_dram
);

   lane_offset_t offset;
   lane_mask_t   size_mask;
   logic [63:0]  rep_data;

   assign offset = i_addr[2:0]; // Taken before the word address clears it.

   // Lanes touched by an access of this size at this offset.
   always_comb
   begin
      case (i_size)
         SIZE_B:
            size_mask = lane_mask_t'(8'h01) << offset;
         SIZE_H:
            size_mask = lane_mask_t'(8'h03) << {offset[2:1], 1'b0};
         SIZE_W:
            size_mask = lane_mask_t'(8'h0f) << {offset[2], 2'b00};
         default:
            size_mask = '1; // Double and unknown sizes.
      endcase
   end

   // Operand copied into every field position.
   always_comb
   begin
      case (i_size)
         SIZE_B:
            rep_data = {8{i_store_data[7:0]}};
         SIZE_H:
            rep_data = {4{i_store_data[15:0]}};
         SIZE_W:
            rep_data = {2{i_store_data[31:0]}};
         default:
            rep_data = i_store_data;
      endcase
   end

   assign o_dram.addr = i_addr[`LSU_DRAM_AW-1:3];
   assign o_dram.we   = {`LSU_LANES{i_op_store}} & size_mask;
   assign o_dram.re   = i_op_load;
   assign o_dram.din  = rep_data;

   // The two strobes share one RAM port.
   always_comb
   begin
      assert final (!(i_op_load && i_op_store))
         else $error("load and store strobes high in the same cycle");
   end

endmodule

`default_nettype wire

// ==== testbench/tb_lsu_top.sv ====
`default_nettype none

`include "lsu_params.svh"

module tb_lsu_top import lsu_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 16;
   localparam int AW           = `LSU_DRAM_AW;

   localparam int OP_IDLE  = 0;
   localparam int OP_STORE = 1;
   localparam int OP_LOAD  = 2;

   // One table row with the response it should produce.
   typedef struct {
      int            op;
      lsu_size_t     size;
      logic [AW-1:0] addr;
      logic          sigext;
      logic [63:0]   data;
      logic [63:0]   exp;
   } entry_t;

   logic          clk = 1'b0;
   logic          arst_n;
   logic          op_load;
   logic          op_store;
   logic          sigext;
   lsu_size_t     size;
   logic [AW-1:0] addr;
   logic [63:0]   store_data;
   logic [63:0]   load_data;
   logic          load_valid;

   logic [7:0]    ref_mem [2**AW]; // Byte-array model of the data RAM.
   entry_t        stim_q [$];
   logic [31:0]   rng_state = 32'h945d_afe9;
   int            test_count = 0;
   int            fail_count = 0;
   logic          table_done = 1'b0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   lsu_top i_lsu_top
   (
      .i_clk        (clk),
      .i_arst_n     (arst_n),
      .i_op_load    (op_load),
      .i_op_store   (op_store),
      .i_sigext     (sigext),
      .i_size       (size),
      .i_addr       (addr),
      .i_store_data (store_data),
      .o_load_data  (load_data),
      .o_load_valid (load_valid)
   );

   function automatic logic [31:0] xorshift32(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [63:0] rand64();
      logic [63:0] r;
      rng_state = xorshift32(rng_state);
      r[63:32] = rng_state;
      rng_state = xorshift32(rng_state);
      r[31:0] = rng_state;
      return r;
   endfunction

   // Odd byte counts behave as a double.
   function automatic int access_bytes(lsu_size_t s);
      int n;
      case (s)
         4'd1:    n = 1;
         4'd2:    n = 2;
         4'd4:    n = 4;
         default: n = 8;
      endcase
      return n;
   endfunction

   function automatic logic [AW-1:0] aligned(logic [AW-1:0] a, int n);
      return a & ~AW'(n - 1);
   endfunction

   task automatic ram_write(lsu_size_t s, logic [AW-1:0] a, logic [63:0] d);
      int            n;
      logic [AW-1:0] base;
      n = access_bytes(s);
      base = aligned(a, n);
      for (int i = 0; i < n; i++)
      begin
         ref_mem[base + i] = d[8*i +: 8]; // Little endian.
      end
   endtask

   function automatic logic [63:0] ram_read(lsu_size_t s, logic [AW-1:0] a, logic ext);
      int            n;
      logic [AW-1:0] base;
      logic [63:0]   v;
      logic          sign;
      n = access_bytes(s);
      base = aligned(a, n);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v[8*i +: 8] = ref_mem[base + i];
      end
      sign = ext & v[8*n - 1];
      for (int j = 8*n; j < 64; j++)
      begin
         v[j] = sign;
      end
      return v;
   endfunction

   task automatic push_store(lsu_size_t s, logic [AW-1:0] a, logic [63:0] d);
      entry_t e;
      e = '{op: OP_STORE, size: s, addr: a, sigext: 1'b0, data: d, exp: '0};
      ram_write(s, a, d);
      stim_q.push_back(e);
   endtask

   task automatic add_load(lsu_size_t s, logic [AW-1:0] a, logic ext);
      entry_t e;
      e = '{op: OP_LOAD, size: s, addr: a, sigext: ext, data: '0, exp: ram_read(s, a, ext)};
      stim_q.push_back(e);
   endtask

   task automatic insert_idle();
      entry_t e;
      e = '{op: OP_IDLE, size: SIZE_D, addr: '0, sigext: 1'b0, data: '0, exp: '0};
      stim_q.push_back(e);
   endtask

   task automatic build_table();
      logic [AW-1:0] dwords [4];
      dwords = '{AW'(0), AW'(16'h1238), AW'(16'h7ff0), AW'(2**AW - 8)};
      for (int i = 0; i < 3; i++)
      begin
         insert_idle(); // Valid must stay low here.
      end
      foreach (dwords[i])
      begin
         push_store(SIZE_D, dwords[i], rand64());
      end
      foreach (dwords[i])
      begin
         add_load(SIZE_D, dwords[i], 1'b0);
      end
      insert_idle();
      // Walk a byte store across every lane of one word.
      push_store(SIZE_D, AW'(16'h0100), rand64());
      for (int k = 0; k < 8; k++)
      begin
         push_store(SIZE_B, AW'(16'h0100 + k), rand64());
         add_load(SIZE_D, AW'(16'h0100), 1'b0);
      end
      // Mixed sign bits in every field.
      push_store(SIZE_D, AW'(16'h0200), 64'h7f0d_7e57_8a1b_43d4);
      for (int k = 0; k < 8; k++)
      begin
         add_load(SIZE_B, AW'(16'h0200 + k), 1'b0);
         add_load(SIZE_B, AW'(16'h0200 + k), 1'b1);
      end
      for (int k = 0; k < 8; k += 2)
      begin
         add_load(SIZE_H, AW'(16'h0200 + k), 1'b0);
         add_load(SIZE_H, AW'(16'h0200 + k), 1'b1);
      end
      for (int k = 0; k < 8; k += 4)
      begin
         add_load(SIZE_W, AW'(16'h0200 + k), 1'b0);
         add_load(SIZE_W, AW'(16'h0200 + k), 1'b1);
      end
      insert_idle();
      push_store(SIZE_D, AW'(16'h0300), rand64());
      push_store(SIZE_D, AW'(16'h0308), rand64());
      push_store(SIZE_H, AW'(16'h0303), rand64()); // Lands on 0x302.
      push_store(SIZE_W, AW'(16'h030e), rand64()); // Lands on 0x30c.
      push_store(4'd3, AW'(16'h0311), rand64());
      add_load(SIZE_D, AW'(16'h0300), 1'b0);
      add_load(SIZE_D, AW'(16'h0308), 1'b0);
      add_load(SIZE_H, AW'(16'h0305), 1'b1);
      add_load(SIZE_W, AW'(16'h030a), 1'b1);
      add_load(SIZE_B, AW'(16'h030f), 1'b1);
      add_load(SIZE_D, AW'(16'h0317), 1'b0);
      insert_idle();
      insert_idle();
   endtask

   task automatic apply_entry(entry_t e);
      op_load    <= (e.op == OP_LOAD);
      op_store   <= (e.op == OP_STORE);
      sigext     <= e.sigext;
      size       <= e.size;
      addr       <= e.addr;
      store_data <= e.data;
   endtask

   function automatic string op_name(int op);
      string s;
      case (op)
         OP_STORE: s = "store";
         OP_LOAD:  s = "load";
         default:  s = "idle";
      endcase
      return s;
   endfunction

   // Response of a row shows up in the cycle after it was applied.
   task automatic check_response(int idx, entry_t e);
      logic exp_valid;
      logic ok;
      exp_valid = (e.op == OP_LOAD);
      ok = 1'b1;
      test_count++;
      assert (load_valid === exp_valid)
      else
      begin
         ok = 1'b0;
         $display("error at %0t ns: o_load_valid expected %b got %b",
                  $time, exp_valid, load_valid);
      end
      if (exp_valid)
      begin
         assert (load_data === e.exp)
         else
         begin
            ok = 1'b0;
            $display("error at %0t ns: o_load_data expected 0x%h got 0x%h",
                     $time, e.exp, load_data);
         end
      end
      if (!ok)
      begin
         fail_count++;
      end
      $display("test %0d %s size %0d addr 0x%h ext %b: %s", idx, op_name(e.op),
               e.size, e.addr, e.sigext, ok ? "ok" : "mismatch");
   endtask

   initial
   begin
      entry_t idle_e;
      idle_e = '{op: OP_IDLE, size: SIZE_D, addr: '0, sigext: 1'b0, data: '0, exp: '0};
      arst_n     = 1'b0;
      op_load    = 1'b0;
      op_store   = 1'b0;
      sigext     = 1'b0;
      size       = SIZE_D;
      addr       = '0;
      store_data = '0;
      build_table();
      table_done = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      for (int k = 0; k <= stim_q.size(); k++)
      begin
         @(posedge clk);
         if (k < stim_q.size())
         begin
            apply_entry(stim_q[k]);
         end
         else
         begin
            apply_entry(idle_e); // Flush the last response.
         end
         @(negedge clk);
         if (k > 0)
         begin
            check_response(k - 1, stim_q[k - 1]);
         end
      end
      $display("%0d tests, %0d passed, %0d failed", test_count,
               test_count - fail_count, fail_count);
      if (fail_count == 0)
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog sized from the table length.
   initial
   begin
      wait (table_done);
      #((RESET_CYCLES + stim_q.size() + 10) * CLK_PERIOD);
      $display("timeout: the test sequence did not finish in the expected time");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/dram_lane.sv ====
`default_nettype none

`include "lsu_params.svh"

module dram_lane
(
   input  wire                    i_clk,
   input  wire [`LSU_DRAM_AW-4:0] i_addr,
   input  wire                    i_we,
   input  wire                    i_re,
   input  wire [7:0]              i_din,
   output logic [7:0]             o_dout
);

   localparam int unsigned DEPTH = 2 ** (`LSU_DRAM_AW - 3);

   logic [7:0] mem [DEPTH];

   always_ff @(posedge i_clk)
   begin
      if (i_we)
      begin
         mem[i_addr] <= i_din;
      end
   end

   // Output holds between reads.
   always_ff @(posedge i_clk)
   begin
      if (i_re)
      begin
         o_dout <= mem[i_addr];
      end
   end

   // Read and write of one lane never share a cycle.
   assert property (@(posedge i_clk) !(i_we && i_re))
      else $error("lane write and read in the same cycle");

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
`default_nettype none

`include "lsu_params.svh"

module lsu_top
(
   input  wire                    i_clk,
   input  wire                    i_arst_n,
   input  wire                    i_op_load,
   input  wire                    i_op_store,
   input  wire                    i_sigext,
   input  wire [3:0]              i_size,
   input  wire [`LSU_DRAM_AW-1:0] i_addr,
   input  wire [63:0]             i_store_data,
   output logic [63:0]            o_load_data,
   output logic                   o_load_valid
);

   dram_if dram_bus ();

   lsu_store_align u_store_align
   (
      .i_op_load    (i_op_load),
      .i_op_store   (i_op_store),
      .i_size       (i_size),
      .i_addr       (i_addr),
      .i_store_data (i_store_data),
      .o_dram       (dram_bus)
   );

   // One byte-wide RAM per lane.
   for (genvar g = 0; g < `LSU_LANES; g++)
   begin : g_lane
      dram_lane u_lane
      (
         .i_clk  (i_clk),
         .i_addr (dram_bus.addr),
         .i_we   (dram_bus.we[g]),
         .i_re   (dram_bus.re),
         .i_din  (dram_bus.din[8*g +: 8]),
         .o_dout (dram_bus.dout[8*g +: 8])
      );
   end

   lsu_load_align u_load_align
   (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_op_load    (i_op_load),
      .i_sigext     (i_sigext),
      .i_size       (i_size),
      .i_offset     (i_addr[2:0]), // Offset before word alignment.
      .i_dram       (dram_bus),
      .o_load_data  (o_load_data),
      .o_load_valid (o_load_valid)
   );

endmodule

`default_nettype wire
